// ==== design/backend_pkg.sv ====
package backend_pkg;

	// datapath widths
	localparam int DATA_W    = 16;
	localparam int PREG_W    = 6;
	localparam int NUM_PREGS = 64;

	// alu mode field
	localparam int MODE_W = 3;

	localparam logic [MODE_W-1:0] MODE_ADD  = 3'd0;
	localparam logic [MODE_W-1:0] MODE_AND  = 3'd1;
	localparam logic [MODE_W-1:0] MODE_OR   = 3'd2;
	localparam logic [MODE_W-1:0] MODE_XOR  = 3'd3;
	localparam logic [MODE_W-1:0] MODE_SLL  = 3'd4;
	localparam logic [MODE_W-1:0] MODE_SRL  = 3'd5;
	localparam logic [MODE_W-1:0] MODE_MOV  = 3'd6;
	localparam logic [MODE_W-1:0] MODE_SLTU = 3'd7;

	// execution lane select
	localparam logic UNIT_ALU  = 1'b0;
	localparam logic UNIT_MULT = 1'b1;

endpackage

// ==== design/backend_ifs.sv ====
`timescale 1ns/1ns

// one decoded operation, broadcast to both lanes
interface ex_op_if;
	import backend_pkg::*;

	logic              vld;
	logic              unit;
	logic [DATA_W-1:0] op1;
	logic [DATA_W-1:0] op2;
	logic [DATA_W-1:0] imm;
	logic              imm_vld;
	logic              ldi;
	logic              inv_rt;
	logic [MODE_W-1:0] mode;
	logic [PREG_W-1:0] dst;
	logic              reg_wrt;

	modport src (
		output vld, unit, op1, op2, imm, imm_vld, ldi, inv_rt, mode, dst, reg_wrt
	);

	modport sink (
		input vld, unit, op1, op2, imm, imm_vld, ldi, inv_rt, mode, dst, reg_wrt
	);

endinterface

// write-back from one lane's ex/wb register
interface wb_if;
	import backend_pkg::*;

	logic              vld;
	logic              wrt;
	logic [PREG_W-1:0] dst;
	logic [DATA_W-1:0] data;

	modport src (
		output vld, wrt, dst, data
	);

	modport sink (
		input vld, wrt, dst, data
	);

endinterface

// ==== design/reg_file.sv ====
`timescale 1ns/1ns

module reg_file (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic [backend_pkg::PREG_W-1:0] rd_a,
	input  logic [backend_pkg::PREG_W-1:0] rd_b,
	output logic [backend_pkg::DATA_W-1:0] rd_a_data,
	output logic [backend_pkg::DATA_W-1:0] rd_b_data,
	wb_if.sink                             wb_alu,
	wb_if.sink                             wb_mult
);
	import backend_pkg::*;

	logic [DATA_W-1:0] regs [NUM_PREGS];

	logic alu_we;
	logic mult_we;

	// a reported write-back only lands when its write flag is set
	assign alu_we  = wb_alu.vld && wb_alu.wrt;
	assign mult_we = wb_mult.vld && wb_mult.wrt;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_PREGS; i++) begin
				regs[i] <= '0;
			end
		end else begin
			if (alu_we) begin
				regs[wb_alu.dst] <= wb_alu.data;
			end
			// multiplier port last so it wins on a clash
			if (mult_we) begin
				regs[wb_mult.dst] <= wb_mult.data;
			end
		end
	end

	// combinational reads, no bypass from this cycle's writes
	assign rd_a_data = regs[rd_a];
	assign rd_b_data = regs[rd_b];

endmodule

// ==== design/operand_stage.sv ====
`timescale 1ns/1ns

module operand_stage (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           issue_vld,
	input  logic                           issue_unit,
	input  logic [backend_pkg::PREG_W-1:0] issue_src1,
	input  logic [backend_pkg::PREG_W-1:0] issue_src2,
	input  logic [backend_pkg::PREG_W-1:0] issue_dst,
	input  logic [backend_pkg::DATA_W-1:0] issue_imm,
	input  logic                           issue_imm_vld,
	input  logic                           issue_ldi,
	input  logic                           issue_inv_rt,
	input  logic [backend_pkg::MODE_W-1:0] issue_mode,
	input  logic                           issue_reg_wrt,
	output logic [backend_pkg::PREG_W-1:0] rd_a,
	output logic [backend_pkg::PREG_W-1:0] rd_b,
	input  logic [backend_pkg::DATA_W-1:0] rd_a_data,
	input  logic [backend_pkg::DATA_W-1:0] rd_b_data,
	ex_op_if.src                           op
);
	import backend_pkg::*;

	// issue register
	logic              iss_vld;
	logic              iss_unit;
	logic [PREG_W-1:0] iss_src1;
	logic [PREG_W-1:0] iss_src2;
	logic [PREG_W-1:0] iss_dst;
	logic [DATA_W-1:0] iss_imm;
	logic              iss_imm_vld;
	logic              iss_ldi;
	logic              iss_inv_rt;
	logic [MODE_W-1:0] iss_mode;
	logic              iss_reg_wrt;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			iss_vld <= 1'b0;
		end else begin
			iss_vld <= issue_vld;
		end
	end

	always_ff @(posedge clk) begin
		iss_unit    <= issue_unit;
		iss_src1    <= issue_src1;
		iss_src2    <= issue_src2;
		iss_dst     <= issue_dst;
		iss_imm     <= issue_imm;
		iss_imm_vld <= issue_imm_vld;
		iss_ldi     <= issue_ldi;
		iss_inv_rt  <= issue_inv_rt;
		iss_mode    <= issue_mode;
		iss_reg_wrt <= issue_reg_wrt;
	end

	// register file is read during the cycle after issue
	assign rd_a = iss_src1;
	assign rd_b = iss_src2;

	// operand register feeding both lanes
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			op.vld <= 1'b0;
		end else begin
			op.vld <= iss_vld;
		end
	end

	always_ff @(posedge clk) begin
		op.unit    <= iss_unit;
		op.op1     <= rd_a_data;
		op.op2     <= rd_b_data;
		op.imm     <= iss_imm;
		op.imm_vld <= iss_imm_vld;
		op.ldi     <= iss_ldi;
		op.inv_rt  <= iss_inv_rt;
		op.mode    <= iss_mode;
		op.dst     <= iss_dst;
		op.reg_wrt <= iss_reg_wrt;
	end

endmodule

// ==== design/alu_unit.sv ====
`timescale 1ns/1ns

module alu_unit (
	input logic   clk,
	input logic   rst_n,
	ex_op_if.sink op,
	wb_if.src     wb
);
	import backend_pkg::*;

	localparam int SHAMT_W = $clog2(DATA_W);

	logic              take;
	logic [DATA_W-1:0] opnd2_sel;
	logic [DATA_W-1:0] opnd2;
	logic              carry_in;
	logic [DATA_W-1:0] sum;
	logic [SHAMT_W-1:0] shamt;
	logic [DATA_W-1:0] result;

	assign take = op.vld && (op.unit == UNIT_ALU);

	// operand 2 select, then optional invert
	assign opnd2_sel = op.imm_vld ? op.imm : op.op2;
	assign opnd2     = op.inv_rt ? ~opnd2_sel : opnd2_sel;

	// inverted add plus one is a subtract
	assign carry_in = op.inv_rt && (op.mode == MODE_ADD);
	assign sum      = op.op1 + opnd2 + DATA_W'(carry_in);
	assign shamt    = opnd2[SHAMT_W-1:0];

	always_comb begin
		result = op.op1;
		case (op.mode)
			MODE_ADD:  result = sum;
			MODE_AND:  result = op.op1 & opnd2;
			MODE_OR:   result = op.op1 | opnd2;
			MODE_XOR:  result = op.op1 ^ opnd2;
			MODE_SLL:  result = op.op1 << shamt;
			MODE_SRL:  result = op.op1 >> shamt;
			MODE_MOV:  result = op.op1;
			MODE_SLTU: result = DATA_W'(op.op1 < opnd2);
		endcase
		// load-immediate overrides the mode
		if (op.ldi) begin
			result = op.imm;
		end
	end

	// ex/wb register
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wb.vld <= 1'b0;
		end else begin
			wb.vld <= take;
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			wb.data <= result;
			wb.dst  <= op.dst;
			wb.wrt  <= op.reg_wrt;
		end
	end

endmodule

// ==== design/mult_unit.sv ====
`timescale 1ns/1ns

module mult_unit #(
	parameter int MULT_LATENCY = 4
) (
	input  logic  clk,
	input  logic  rst_n,
	ex_op_if.sink op,
	output logic  free,
	wb_if.src     wb
);
	import backend_pkg::*;

	localparam int CNT_W = $clog2(MULT_LATENCY) + 1;

	logic              busy;
	logic              offered;
	logic              take;
	logic [CNT_W-1:0]  cnt;
	logic [DATA_W-1:0] src_b;
	logic [DATA_W-1:0] mul_a;
	logic [DATA_W-1:0] mul_b;
	logic [DATA_W-1:0] prod_lo;

	assign offered = op.vld && (op.unit == UNIT_MULT);
	// a multiply offered while busy is simply lost
	assign take    = offered && !busy;
	assign free    = !busy && !offered;

	assign src_b   = op.imm_vld ? op.imm : op.op2;
	assign prod_lo = mul_a * mul_b;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy   <= 1'b0;
			cnt    <= '0;
			wb.vld <= 1'b0;
		end else begin
			wb.vld <= 1'b0;
			if (take) begin
				cnt <= CNT_W'(MULT_LATENCY - 1);
				if (MULT_LATENCY == 1) begin
					wb.vld <= 1'b1;
				end else begin
					busy <= 1'b1;
				end
			end else if (busy) begin
				cnt <= cnt - 1'b1;
				// last busy cycle
				if (cnt == CNT_W'(1)) begin
					busy   <= 1'b0;
					wb.vld <= 1'b1;
				end
			end
		end
	end

	// operand latches and result word
	always_ff @(posedge clk) begin
		if (take) begin
			mul_a  <= op.op1;
			mul_b  <= src_b;
			wb.dst <= op.dst;
			wb.wrt <= op.reg_wrt;
			if (MULT_LATENCY == 1) begin
				wb.data <= op.op1 * src_b;
			end
		end else if (busy && cnt == CNT_W'(1)) begin
			wb.data <= prod_lo;
		end
	end

endmodule

// ==== design/exec_backend.sv ====
`timescale 1ns/1ns

module exec_backend #(
	parameter int MULT_LATENCY = 4
) (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           issue_vld,
	input  logic                           issue_unit,
	input  logic [backend_pkg::PREG_W-1:0] issue_src1,
	input  logic [backend_pkg::PREG_W-1:0] issue_src2,
	input  logic [backend_pkg::PREG_W-1:0] issue_dst,
	input  logic [backend_pkg::DATA_W-1:0] issue_imm,
	input  logic                           issue_imm_vld,
	input  logic                           issue_ldi,
	input  logic                           issue_inv_rt,
	input  logic [backend_pkg::MODE_W-1:0] issue_mode,
	input  logic                           issue_reg_wrt,
	output logic                           mult_free,
	output logic                           alu_wb_vld,
	output logic [backend_pkg::PREG_W-1:0] alu_wb_dst,
	output logic [backend_pkg::DATA_W-1:0] alu_wb_data,
	output logic                           mult_wb_vld,
	output logic [backend_pkg::PREG_W-1:0] mult_wb_dst,
	output logic [backend_pkg::DATA_W-1:0] mult_wb_data
);

	logic [backend_pkg::PREG_W-1:0] rd_a;
	logic [backend_pkg::PREG_W-1:0] rd_b;
	logic [backend_pkg::DATA_W-1:0] rd_a_data;
	logic [backend_pkg::DATA_W-1:0] rd_b_data;

	ex_op_if ex_op ();
	wb_if    alu_wb ();
	wb_if    mult_wb ();

	operand_stage i_operand_stage (
		.clk           (clk),
		.rst_n         (rst_n),
		.issue_vld     (issue_vld),
		.issue_unit    (issue_unit),
		.issue_src1    (issue_src1),
		.issue_src2    (issue_src2),
		.issue_dst     (issue_dst),
		.issue_imm     (issue_imm),
		.issue_imm_vld (issue_imm_vld),
		.issue_ldi     (issue_ldi),
		.issue_inv_rt  (issue_inv_rt),
		.issue_mode    (issue_mode),
		.issue_reg_wrt (issue_reg_wrt),
		.rd_a          (rd_a),
		.rd_b          (rd_b),
		.rd_a_data     (rd_a_data),
		.rd_b_data     (rd_b_data),
		.op            (ex_op.src)
	);

	reg_file i_reg_file (
		.clk       (clk),
		.rst_n     (rst_n),
		.rd_a      (rd_a),
		.rd_b      (rd_b),
		.rd_a_data (rd_a_data),
		.rd_b_data (rd_b_data),
		.wb_alu    (alu_wb.sink),
		.wb_mult   (mult_wb.sink)
	);

	alu_unit i_alu_unit (
		.clk   (clk),
		.rst_n (rst_n),
		.op    (ex_op.sink),
		.wb    (alu_wb.src)
	);

	mult_unit #(
		.MULT_LATENCY (MULT_LATENCY)
	) i_mult_unit (
		.clk   (clk),
		.rst_n (rst_n),
		.op    (ex_op.sink),
		.free  (mult_free),
		.wb    (mult_wb.src)
	);

	// write-backs out to the top-level ports
	assign alu_wb_vld   = alu_wb.vld;
	assign alu_wb_dst   = alu_wb.dst;
	assign alu_wb_data  = alu_wb.data;
	assign mult_wb_vld  = mult_wb.vld;
	assign mult_wb_dst  = mult_wb.dst;
	assign mult_wb_data = mult_wb.data;

endmodule

// ==== tb/tb_exec_backend.sv ====
`timescale 1ns/1ns

module tb_exec_backend;
	import backend_pkg::*;

	localparam int MULT_LATENCY = 4;

	logic              clk;
	logic              rst_n;
	logic              issue_vld;
	logic              issue_unit;
	logic [PREG_W-1:0] issue_src1;
	logic [PREG_W-1:0] issue_src2;
	logic [PREG_W-1:0] issue_dst;
	logic [DATA_W-1:0] issue_imm;
	logic              issue_imm_vld;
	logic              issue_ldi;
	logic              issue_inv_rt;
	logic [MODE_W-1:0] issue_mode;
	logic              issue_reg_wrt;
	logic              mult_free;
	logic              alu_wb_vld;
	logic [PREG_W-1:0] alu_wb_dst;
	logic [DATA_W-1:0] alu_wb_data;
	logic              mult_wb_vld;
	logic [PREG_W-1:0] mult_wb_dst;
	logic [DATA_W-1:0] mult_wb_data;

	// expected write-backs, one set of queues per lane
	string             test_lines[$];
	string             alu_name_q[$];
	logic [PREG_W-1:0] alu_dst_q[$];
	logic [DATA_W-1:0] alu_data_q[$];
	string             mult_name_q[$];
	logic [PREG_W-1:0] mult_dst_q[$];
	logic [DATA_W-1:0] mult_data_q[$];

	int   cycles = 0;
	int   max_cycles = 0;
	logic mult_started = 1'b0;

	exec_backend #(
		.MULT_LATENCY (MULT_LATENCY)
	) i_exec_backend (
		.clk           (clk),
		.rst_n         (rst_n),
		.issue_vld     (issue_vld),
		.issue_unit    (issue_unit),
		.issue_src1    (issue_src1),
		.issue_src2    (issue_src2),
		.issue_dst     (issue_dst),
		.issue_imm     (issue_imm),
		.issue_imm_vld (issue_imm_vld),
		.issue_ldi     (issue_ldi),
		.issue_inv_rt  (issue_inv_rt),
		.issue_mode    (issue_mode),
		.issue_reg_wrt (issue_reg_wrt),
		.mult_free     (mult_free),
		.alu_wb_vld    (alu_wb_vld),
		.alu_wb_dst    (alu_wb_dst),
		.alu_wb_data   (alu_wb_data),
		.mult_wb_vld   (mult_wb_vld),
		.mult_wb_dst   (mult_wb_dst),
		.mult_wb_data  (mult_wb_data)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#2 clk = ~clk;
		end
	end

	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("Done: errors found");
		$fatal(1, "simulation stopped");
	endtask

	task automatic compare_wb(input string lane, input string tname,
			input logic [PREG_W-1:0] exp_dst, input logic [DATA_W-1:0] exp_data,
			input logic [PREG_W-1:0] act_dst, input logic [DATA_W-1:0] act_data);
		assert (act_dst === exp_dst) else
			stop_run($sformatf("** Error: %s %s dst expected %0d, actual %0d",
				tname, lane, exp_dst, act_dst));
		assert (act_data === exp_data) else
			stop_run($sformatf("** Error: %s %s data expected %h, actual %h",
				tname, lane, exp_data, act_data));
	endtask

	// monitor, sampling values from before each rising edge
	always @(posedge clk) begin
		cycles = cycles + 1;
		if (max_cycles > 0 && cycles >= max_cycles) begin
			stop_run($sformatf("timeout after %0d cycles, write-backs still pending", cycles));
		end
		if (rst_n === 1'b1) begin
			if (alu_wb_vld !== 1'b0) begin
				assert (alu_name_q.size() > 0) else
					stop_run("ALU lane wrote back with no result expected");
				compare_wb("alu", alu_name_q.pop_front(), alu_dst_q.pop_front(),
					alu_data_q.pop_front(), alu_wb_dst, alu_wb_data);
			end
			if (mult_wb_vld !== 1'b0) begin
				assert (mult_name_q.size() > 0) else
					stop_run("multiplier lane wrote back with no result expected");
				assert (mult_started) else
					stop_run("mult_free never went low before the multiplier write-back");
				assert (mult_free === 1'b1) else
					stop_run("mult_free did not return high with the multiplier write-back");
				compare_wb("mult", mult_name_q.pop_front(), mult_dst_q.pop_front(),
					mult_data_q.pop_front(), mult_wb_dst, mult_wb_data);
				mult_started = 1'b0;
			end else if (mult_started) begin
				assert (mult_free === 1'b0) else
					stop_run("mult_free went high before the multiplier write-back");
			end else if (mult_name_q.size() > 0 && mult_free === 1'b0) begin
				mult_started = 1'b1;
			end
		end
	end

	// one test line: drive the issue port, queue the expected write-back
	task automatic issue_test(input string line);
		string             tname;
		int                gap;
		int                n;
		logic              exp_wb;
		logic              lane;
		logic [PREG_W-1:0] exp_dst;
		logic [DATA_W-1:0] exp_data;
		n = $sscanf(line, "%s %d %d %d %d %d %h %d %d %d %d %d %d %d %d %h",
			tname, gap, issue_unit, issue_src1, issue_src2, issue_dst, issue_imm,
			issue_imm_vld, issue_ldi, issue_inv_rt, issue_mode, issue_reg_wrt,
			exp_wb, lane, exp_dst, exp_data);
		assert (n == 16 && gap > 0) else
			stop_run($sformatf("malformed test line: %s", line));
		issue_vld = 1'b1;
		if (exp_wb && lane == UNIT_MULT) begin
			mult_name_q.push_back(tname);
			mult_dst_q.push_back(exp_dst);
			mult_data_q.push_back(exp_data);
		end else if (exp_wb) begin
			alu_name_q.push_back(tname);
			alu_dst_q.push_back(exp_dst);
			alu_data_q.push_back(exp_data);
		end
		@(negedge clk);
		issue_vld = 1'b0;
		repeat (gap - 1) @(negedge clk);
	endtask

	initial begin
		int    fd;
		string line;
		rst_n = 1'b0;
		issue_vld = 1'b0;
		issue_unit = UNIT_ALU;
		issue_src1 = '0;
		issue_src2 = '0;
		issue_dst = '0;
		issue_imm = '0;
		issue_imm_vld = 1'b0;
		issue_ldi = 1'b0;
		issue_inv_rt = 1'b0;
		issue_mode = MODE_ADD;
		issue_reg_wrt = 1'b0;

		fd = $fopen("tb/backend_tests.txt", "r");
		if (fd == 0) begin
			stop_run("cannot open tb/backend_tests.txt");
		end
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() > 1 && line[0] != "#") begin
				test_lines.push_back(line);
			end
		end
		$fclose(fd);
		max_cycles = test_lines.size() * (MULT_LATENCY + 8) + 40;

		repeat (5) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		assert (mult_free === 1'b1) else
			stop_run("mult_free is not high after reset");

		foreach (test_lines[i]) begin
			issue_test(test_lines[i]);
		end

		while (alu_name_q.size() > 0 || mult_name_q.size() > 0) begin
			@(negedge clk);
		end
		// idle window for stray write-backs
		repeat (MULT_LATENCY + 4) @(negedge clk);
		$display("Done: no errors");
		$finish;
	end

endmodule

// ==== tb/backend_tests.txt ====
# name gap unit src1 src2 dst imm(hex) imm_vld ldi inv_rt mode reg_wrt
#   then: wb_expected lane(0 alu, 1 mult) exp_dst exp_data(hex)
mov_zero  3 0  5  0  6 0000 0 0 0 6 1 1 0  6 0000
ldi_a     3 0  0  0  1 1234 0 1 0 0 1 1 0  1 1234
ldi_b     3 0  0  0  2 00f3 0 1 0 0 1 1 0  2 00f3
mov_ldi   3 0  1  0  7 0000 0 0 0 6 1 1 0  7 1234
add_reg   1 0  1  2  8 0000 0 0 0 0 1 1 0  8 1327
add_imm   1 0  1  0  9 0010 1 0 0 0 1 1 0  9 1244
sub_reg   1 0  1  2 10 0000 0 0 1 0 1 1 0 10 1141
and_reg   1 0  1  2 11 0000 0 0 0 1 1 1 0 11 0030
and_imm   1 0  1  0 12 0ff0 1 0 0 1 1 1 0 12 0230
or_reg    1 0  1  2 13 0000 0 0 0 2 1 1 0 13 12f7
or_imm    1 0  1  0 14 8001 1 0 0 2 1 1 0 14 9235
xor_reg   1 0  1  2 15 0000 0 0 0 3 1 1 0 15 12c7
xor_inv   1 0  1  2 16 0000 0 0 1 3 1 1 0 16 ed38
xor_imm   1 0  1  0 17 ffff 1 0 0 3 1 1 0 17 edcb
sll_reg   1 0  1  2 18 0000 0 0 0 4 1 1 0 18 91a0
sll_imm   1 0  1  0 19 0014 1 0 0 4 1 1 0 19 2340
srl_reg   1 0  1  2 20 0000 0 0 0 5 1 1 0 20 0246
srl_imm   1 0  1  0 21 0028 1 0 0 5 1 1 0 21 0012
mov_imm   1 0  1  0 22 5555 1 0 0 6 1 1 0 22 1234
sltu_reg  1 0  1  2 23 0000 0 0 0 7 1 1 0 23 0000
sltu_imm  1 0  1  0 24 2000 1 0 0 7 1 1 0 24 0001
nowrt     3 0  0  0  1 beef 0 1 0 0 0 1 0  1 beef
nowrt_chk 1 0  1  0 25 0000 0 0 0 6 1 1 0 25 1234
mul_a     1 1  1  2 26 0000 0 0 0 0 1 1 1 26 475c
mul_drop  1 1  1  0 27 0003 1 0 0 0 1 0 1 27 0003
par_a     1 0  1  0 28 0001 1 0 0 0 1 1 0 28 1235
par_b     1 0  2  0 29 0f00 1 0 0 2 1 1 0 29 0ff3
par_c     7 0  0  0 30 0a0a 0 1 0 0 1 1 0 30 0a0a
mul_imm   7 1  2  0 31 0101 1 0 0 0 1 1 1 31 f3f3
mul_chk   3 0 26  0 32 0000 0 0 0 6 1 1 0 32 475c
drop_chk  3 0 27  0 33 0000 0 0 0 6 1 1 0 33 0000

// ==== list.f ====
design/backend_pkg.sv
design/backend_ifs.sv
design/reg_file.sv
design/operand_stage.sv
design/alu_unit.sv
design/mult_unit.sv
design/exec_backend.sv
tb/tb_exec_backend.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_exec_backend
OBJ_DIR   ?= obj_dir
FILELIST  ?= list.f
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Done: no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
